/* hdl/muldiv_dispatch.sv */
`timescale 1ns/100ps

module muldiv_dispatch (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  muldiv_op_pkg::funct3_t  funct3_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output logic                    mul_req_valid_o,
  output muldiv_op_pkg::mul_op_e  mul_op_o,
  output logic                    div_req_valid_o,
  output muldiv_op_pkg::div_op_e  div_op_o,
  input  logic                    mul_resp_valid_i,
  input  logic                    div_resp_valid_i,
  input  muldiv_width_pkg::xlen_t mul_resp_value_i,
  input  muldiv_width_pkg::xlen_t div_resp_value_i,
  output logic                    resp_valid_o,
  output muldiv_width_pkg::xlen_t resp_value_o
);

  muldiv_op_pkg::unit_e busy_q, unit_sel;
  logic                 accept;

  always_comb begin
    case (funct3_i)
      muldiv_op_pkg::F3_MUL, muldiv_op_pkg::F3_MULH,
      muldiv_op_pkg::F3_MULHSU, muldiv_op_pkg::F3_MULHU: unit_sel = muldiv_op_pkg::UNIT_MUL;
      muldiv_op_pkg::F3_DIV, muldiv_op_pkg::F3_DIVU,
      muldiv_op_pkg::F3_REM, muldiv_op_pkg::F3_REMU:     unit_sel = muldiv_op_pkg::UNIT_DIV;
      default:                                           unit_sel = muldiv_op_pkg::UNIT_NONE;
    endcase
  end

  // Low funct3 bits line up with both op encodings
  assign mul_op_o = muldiv_op_pkg::mul_op_e'(funct3_i[1:0]);
  assign div_op_o = muldiv_op_pkg::div_op_e'(funct3_i[1:0]);

  // Only the busy unit may answer
  assign resp_valid_o = (busy_q == muldiv_op_pkg::UNIT_MUL && mul_resp_valid_i) ||
                        (busy_q == muldiv_op_pkg::UNIT_DIV && div_resp_valid_i);
  assign resp_value_o = (busy_q == muldiv_op_pkg::UNIT_DIV) ? div_resp_value_i
                                                             : mul_resp_value_i;

  // Free again in the response cycle
  assign req_ready_o = (busy_q == muldiv_op_pkg::UNIT_NONE) || resp_valid_o;
  assign accept      = req_valid_i && req_ready_o;

  assign mul_req_valid_o = accept && (unit_sel == muldiv_op_pkg::UNIT_MUL);
  assign div_req_valid_o = accept && (unit_sel == muldiv_op_pkg::UNIT_DIV);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= muldiv_op_pkg::UNIT_NONE;
    end else if (accept) begin
      busy_q <= unit_sel;
    end else if (resp_valid_o) begin
      busy_q <= muldiv_op_pkg::UNIT_NONE;
    end
  end

endmodule

/* hdl/muldiv_div.sv */
`timescale 1ns/100ps

module muldiv_div (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  muldiv_width_pkg::xlen_t operand_a_i,
  input  muldiv_width_pkg::xlen_t operand_b_i,
  input  muldiv_op_pkg::div_op_e  req_op_i,
  input  logic                    req_word_i,
  input  logic                    req_valid_i,
  output logic                    resp_valid_o,
  output muldiv_width_pkg::xlen_t resp_value_o
);

  typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_ITERATE,
    STATE_FINISH
  } state_e;

  state_e     state_q, state_d;
  logic [5:0] count_q, count_d;
  logic       start;

  logic                           op_signed;
  logic                           sign_a, sign_b;
  muldiv_width_pkg::ext_operand_t ext_a, ext_b;
  muldiv_width_pkg::xlen_t        abs_a, abs_b;
  logic                           div_zero, overflow;

  muldiv_width_pkg::xlen_t        divisor_q;
  muldiv_width_pkg::xlen_t        quo_q, quo_d;
  muldiv_width_pkg::xlen_t        rem_q, rem_d;
  muldiv_width_pkg::ext_operand_t rem_shift;
  logic                           rem_ge;

  logic word_q, rem_sel_q, quo_neg_q, rem_neg_q;
  logic div_zero_q, overflow_q;

  muldiv_width_pkg::xlen_t quo_res, rem_res, result;

  assign start = (state_q == STATE_IDLE) && req_valid_i;

  // Operand magnitudes with word forms narrowed to 32 bits
  assign op_signed = ~req_op_i[0];
  assign sign_a    = op_signed & (req_word_i ? operand_a_i[31] : operand_a_i[63]);
  assign sign_b    = op_signed & (req_word_i ? operand_b_i[31] : operand_b_i[63]);
  assign ext_a     = req_word_i ? {{33{sign_a}}, operand_a_i[31:0]} : {sign_a, operand_a_i};
  assign ext_b     = req_word_i ? {{33{sign_b}}, operand_b_i[31:0]} : {sign_b, operand_b_i};
  assign abs_a     = sign_a ? -ext_a[63:0] : ext_a[63:0];
  assign abs_b     = sign_b ? -ext_b[63:0] : ext_b[63:0];

  assign div_zero = req_word_i ? (operand_b_i[31:0] == '0) : (operand_b_i == '0);
  assign overflow = op_signed & (req_word_i ?
      (operand_a_i[31:0] == 32'h8000_0000) && (operand_b_i[31:0] == '1) :
      (operand_a_i == 64'h8000_0000_0000_0000) && (operand_b_i == '1));

  // Restoring step
  assign rem_shift = {rem_q, quo_q[63]};
  assign rem_ge    = rem_shift >= {1'b0, divisor_q};

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    quo_d   = quo_q;
    rem_d   = rem_q;

    case (state_q)
      STATE_IDLE: begin
        if (req_valid_i) begin
          // Word dividend starts in the top half so 32 shifts suffice
          quo_d   = req_word_i ? {abs_a[31:0], 32'h0} : abs_a;
          rem_d   = '0;
          count_d = req_word_i ? 6'd31 : 6'd63;
          state_d = STATE_ITERATE;
        end
      end
      STATE_ITERATE: begin
        quo_d   = {quo_q[62:0], rem_ge};
        rem_d   = rem_ge ? rem_shift[63:0] - divisor_q : rem_shift[63:0];
        count_d = count_q - 6'd1;
        if (count_q == '0) begin
          state_d = STATE_FINISH;
        end
      end
      default: state_d = STATE_IDLE;
    endcase
  end

  always_comb begin
    quo_res = quo_neg_q ? -quo_q : quo_q;
    rem_res = rem_neg_q ? -rem_q : rem_q;
    if (div_zero_q) begin
      quo_res = '1;
    end
    if (overflow_q) begin
      quo_res = word_q ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
      rem_res = '0;
    end
    result = rem_sel_q ? rem_res : quo_res;
    if (word_q) begin
      result = {{32{result[31]}}, result[31:0]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= STATE_IDLE;
      count_q      <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      count_q      <= count_d;
      resp_valid_o <= state_q == STATE_FINISH;
    end
  end

  always_ff @(posedge clk_i) begin
    quo_q <= quo_d;
    rem_q <= rem_d;
    if (start) begin
      divisor_q  <= abs_b;
      word_q     <= req_word_i;
      rem_sel_q  <= req_op_i[1];
      quo_neg_q  <= sign_a ^ sign_b;
      rem_neg_q  <= sign_a;
      div_zero_q <= div_zero;
      overflow_q <= overflow;
    end
    if (state_q == STATE_FINISH) begin
      resp_value_o <= result;
    end
  end

endmodule

/* hdl/muldiv_mul.sv */
`timescale 1ns/100ps

module muldiv_mul (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  muldiv_width_pkg::xlen_t operand_a_i,
  input  muldiv_width_pkg::xlen_t operand_b_i,
  input  muldiv_op_pkg::mul_op_e  req_op_i,
  input  logic                    req_word_i,
  input  logic                    req_valid_i,
  output logic                    resp_valid_o,
  output muldiv_width_pkg::xlen_t resp_value_o
);

  // One 17x17 MAC per cycle gives 4 cycles for MULW, 11 for MUL and 17 for MULH*

  typedef enum logic {
    STATE_IDLE,
    STATE_PROGRESS
  } state_e;

  state_e     state_q, state_d;
  logic [3:0] step_q, step_d;
  logic [1:0] a_idx, b_idx;

  muldiv_width_pkg::ext_operand_t a_q, a_d;
  muldiv_width_pkg::ext_operand_t b_q, b_d;
  logic                           op_low_q, op_low_d;
  logic                           op_word_q, op_word_d;

  muldiv_width_pkg::mac_digit_t mac_a, mac_b;
  muldiv_width_pkg::mac_accum_t accum_q, accum_d;
  muldiv_width_pkg::mac_accum_t mac_sum;
  muldiv_width_pkg::mac_accum_t carry;

  logic                    valid_d;
  muldiv_width_pkg::xlen_t value_d;

  function automatic muldiv_width_pkg::mac_digit_t pick_digit(
    input muldiv_width_pkg::ext_operand_t op,
    input logic [1:0]                     idx
  );
    case (idx)
      2'd0:    pick_digit = {1'b0, op[15:0]};
      2'd1:    pick_digit = {1'b0, op[31:16]};
      2'd2:    pick_digit = {1'b0, op[47:32]};
      default: pick_digit = op[64:48];
    endcase
  endfunction

  // Digit pairs walked column by column from the low column up
  always_comb begin
    case (step_q)
      4'd0:    {a_idx, b_idx} = {2'd0, 2'd0};
      4'd1:    {a_idx, b_idx} = {2'd1, 2'd0};
      4'd2:    {a_idx, b_idx} = {2'd0, 2'd1};
      4'd3:    {a_idx, b_idx} = {2'd0, 2'd2};
      4'd4:    {a_idx, b_idx} = {2'd1, 2'd1};
      4'd5:    {a_idx, b_idx} = {2'd2, 2'd0};
      4'd6:    {a_idx, b_idx} = {2'd3, 2'd0};
      4'd7:    {a_idx, b_idx} = {2'd2, 2'd1};
      4'd8:    {a_idx, b_idx} = {2'd1, 2'd2};
      4'd9:    {a_idx, b_idx} = {2'd0, 2'd3};
      4'd10:   {a_idx, b_idx} = {2'd1, 2'd3};
      4'd11:   {a_idx, b_idx} = {2'd2, 2'd2};
      4'd12:   {a_idx, b_idx} = {2'd3, 2'd1};
      4'd13:   {a_idx, b_idx} = {2'd3, 2'd2};
      4'd14:   {a_idx, b_idx} = {2'd2, 2'd3};
      default: {a_idx, b_idx} = {2'd3, 2'd3};
    endcase
  end

  assign mac_a   = pick_digit(a_q, a_idx);
  assign mac_b   = pick_digit(b_q, b_idx);
  assign mac_sum = $signed(accum_q) + $signed(mac_a) * $signed(mac_b);

  // Carry into the next column
  assign carry = {{16{mac_sum[34]}}, mac_sum[34:16]};

  always_comb begin
    state_d   = state_q;
    step_d    = step_q;
    a_d       = a_q;
    b_d       = b_q;
    op_low_d  = op_low_q;
    op_word_d = op_word_q;
    accum_d   = accum_q;
    valid_d   = 1'b0;
    value_d   = resp_value_o;

    case (state_q)
      STATE_IDLE: begin
        if (req_valid_i) begin
          a_d = {(req_op_i != muldiv_op_pkg::MUL_OP_MULHU) & operand_a_i[63], operand_a_i};
          b_d = {~req_op_i[1] & operand_b_i[63], operand_b_i};
          op_low_d  = req_op_i == muldiv_op_pkg::MUL_OP_MUL;
          op_word_d = req_word_i;
          accum_d   = '0;
          step_d    = '0;
          state_d   = STATE_PROGRESS;
        end
      end
      STATE_PROGRESS: begin
        accum_d = mac_sum;
        step_d  = step_q + 4'd1;
        case (step_q)
          4'd0: begin
            value_d[15:0] = mac_sum[15:0];
            accum_d       = carry;
          end
          4'd2: begin
            // Sign extension already right for word results
            value_d[63:16] = {{32{mac_sum[15]}}, mac_sum[15:0]};
            accum_d        = carry;
            if (op_word_q) begin
              valid_d = 1'b1;
              state_d = STATE_IDLE;
            end
          end
          4'd5: begin
            value_d[47:32] = mac_sum[15:0];
            accum_d        = carry;
          end
          4'd9: begin
            value_d[63:48] = mac_sum[15:0];
            accum_d        = carry;
            if (op_low_q) begin
              valid_d = 1'b1;
              state_d = STATE_IDLE;
            end
          end
          // High half overwrites the low half from here on
          4'd12: begin
            value_d[15:0] = mac_sum[15:0];
            accum_d       = carry;
          end
          4'd14: begin
            value_d[31:16] = mac_sum[15:0];
            accum_d        = carry;
          end
          4'd15: begin
            value_d[63:32] = mac_sum[31:0];
            valid_d        = 1'b1;
            state_d        = STATE_IDLE;
          end
          default: ;
        endcase
      end
      default: state_d = STATE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= STATE_IDLE;
      step_q       <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      step_q       <= step_d;
      resp_valid_o <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    a_q          <= a_d;
    b_q          <= b_d;
    op_low_q     <= op_low_d;
    op_word_q    <= op_word_d;
    accum_q      <= accum_d;
    resp_value_o <= value_d;
  end

endmodule

/* hdl/muldiv_op_pkg.sv */
package muldiv_op_pkg;

  // funct3 field of the OP/OP-32 major opcodes with funct7 = 1
  typedef logic [2:0] funct3_t;

  localparam funct3_t F3_MUL    = 3'b000;
  localparam funct3_t F3_MULH   = 3'b001;
  localparam funct3_t F3_MULHSU = 3'b010;
  localparam funct3_t F3_MULHU  = 3'b011;
  localparam funct3_t F3_DIV    = 3'b100;
  localparam funct3_t F3_DIVU   = 3'b101;
  localparam funct3_t F3_REM    = 3'b110;
  localparam funct3_t F3_REMU   = 3'b111;

  // Bit 1 clear means operand b is signed
  typedef enum logic [1:0] {
    MUL_OP_MUL    = 2'b00,
    MUL_OP_MULH   = 2'b01,
    MUL_OP_MULHSU = 2'b10,
    MUL_OP_MULHU  = 2'b11
  } mul_op_e;

  // Bit 0 selects unsigned, bit 1 selects remainder
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

  typedef enum logic [1:0] {
    UNIT_NONE = 2'b00,
    UNIT_MUL  = 2'b01,
    UNIT_DIV  = 2'b10
  } unit_e;

endpackage

/* hdl/muldiv_top.sv */
`timescale 1ns/100ps

module muldiv_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  muldiv_width_pkg::xlen_t operand_a_i,
  input  muldiv_width_pkg::xlen_t operand_b_i,
  input  muldiv_op_pkg::funct3_t  funct3_i,
  input  logic                    word_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output muldiv_width_pkg::xlen_t resp_value_o
);

  logic                    mul_req_valid;
  logic                    div_req_valid;
  muldiv_op_pkg::mul_op_e  mul_op;
  muldiv_op_pkg::div_op_e  div_op;
  logic                    mul_resp_valid;
  logic                    div_resp_valid;
  muldiv_width_pkg::xlen_t mul_resp_value;
  muldiv_width_pkg::xlen_t div_resp_value;

  muldiv_dispatch u_dispatch (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .funct3_i         (funct3_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .mul_req_valid_o  (mul_req_valid),
    .mul_op_o         (mul_op),
    .div_req_valid_o  (div_req_valid),
    .div_op_o         (div_op),
    .mul_resp_valid_i (mul_resp_valid),
    .div_resp_valid_i (div_resp_valid),
    .mul_resp_value_i (mul_resp_value),
    .div_resp_value_i (div_resp_value),
    .resp_valid_o     (resp_valid_o),
    .resp_value_o     (resp_value_o)
  );

  muldiv_mul u_mul (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (mul_op),
    .req_word_i   (word_i),
    .req_valid_i  (mul_req_valid),
    .resp_valid_o (mul_resp_valid),
    .resp_value_o (mul_resp_value)
  );

  muldiv_div u_div (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (div_op),
    .req_word_i   (word_i),
    .req_valid_i  (div_req_valid),
    .resp_valid_o (div_resp_valid),
    .resp_value_o (div_resp_value)
  );

endmodule

/* hdl/muldiv_width_pkg.sv */
package muldiv_width_pkg;

  localparam int unsigned XLEN = 64;

  // One 16-bit digit plus a sign bit for the top digit
  localparam int unsigned DIGIT_W = 17;

  // Product of two digits plus room for column sums
  localparam int unsigned ACCUM_W = 2 * DIGIT_W + 1;

  typedef logic [XLEN-1:0] xlen_t;

  // Operand with its sign-extension bit on top
  typedef logic [XLEN:0] ext_operand_t;

  typedef logic [DIGIT_W-1:0] mac_digit_t;

  typedef logic [ACCUM_W-1:0] mac_accum_t;

endpackage

/* run_verilator.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_muldiv -f vlog.f -Mdir obj_dir -o sim_muldiv \
  && ./obj_dir/sim_muldiv > sim.log 2>&1 \
  || echo "Build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log 2>/dev/null \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

/* testbench/tb_muldiv.sv */
`timescale 1ns/100ps

module tb_muldiv;

  localparam logic [31:0] SEED        = 32'h2694248a;
  localparam int          N_DIRECTED  = 117;
  localparam int          N_RANDOM    = 200;
  localparam int          N_BURST     = 8;
  localparam int          N_TESTS     = N_DIRECTED + N_RANDOM + N_BURST;
  localparam int          CYCLE_LIMIT = N_TESTS * 70 + 200;

  logic                    clk_i;
  logic                    rst_ni;
  muldiv_width_pkg::xlen_t operand_a_i;
  muldiv_width_pkg::xlen_t operand_b_i;
  muldiv_op_pkg::funct3_t  funct3_i;
  logic                    word_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  logic                    resp_valid_o;
  muldiv_width_pkg::xlen_t resp_value_o;

  int accepted;
  int responses;
  int errors;
  int sent;
  int top_errors;
  int cycles = 0;

  muldiv_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .funct3_i     (funct3_i),
    .word_i       (word_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o)
  );

  tb_muldiv_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .funct3_i     (funct3_i),
    .word_i       (word_i),
    .req_valid_i  (req_valid_i),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .resp_value_i (resp_value_o),
    .accepted_o   (accepted),
    .responses_o  (responses),
    .errors_o     (errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a response never arrived", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Corner operands with garbage above bit 31 in the last two
  task automatic pick_pair(input int idx, output logic [63:0] a, output logic [63:0] b);
    case (idx)
      0:       {a, b} = {64'h0, 64'h0123_4567_89ab_cdef};
      1:       {a, b} = {64'h1, 64'hfedc_ba98_7654_3210};
      2:       {a, b} = {64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff};
      3:       {a, b} = {64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000};
      4:       {a, b} = {64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff};
      5:       {a, b} = {64'h7fff_ffff_ffff_fff3, 64'hffff_ffff_ffff_fffd};
      6:       {a, b} = {64'h0000_1234_5678_9abc, 64'h0};
      7:       {a, b} = {64'h1234_5678_8000_0000, 64'hdead_beef_ffff_ffff};
      default: {a, b} = {64'hcafe_f00d_ffff_fff9, 64'h0bad_0000_0000_0000};
    endcase
  endtask

  // Returns 1 ns after the accepting edge with req_valid_i still high
  task automatic send_request(input logic [63:0] a, input logic [63:0] b,
                              input logic [2:0] f3, input logic w);
    operand_a_i = a;
    operand_b_i = b;
    funct3_i    = f3;
    word_i      = w;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    sent++;
  endtask

  task automatic wait_response();
    @(negedge clk_i);
    while (!resp_valid_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_test(input logic [63:0] a, input logic [63:0] b,
                          input logic [2:0] f3, input logic w);
    send_request(a, b, f3, w);
    req_valid_i = 1'b0;
    wait_response();
  endtask

  initial begin
    logic [31:0] rnd;
    logic [63:0] a, b;
    logic [2:0]  f3;
    logic        w;
    rst_ni      = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    funct3_i    = '0;
    word_i      = 1'b0;
    req_valid_i = 1'b0;
    sent        = 0;
    top_errors  = 0;
    void'($urandom(SEED));
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;

    // Word forms only exist for MUL and the divides
    for (int wi = 0; wi < 2; wi++) begin
      for (int fi = 0; fi < 8; fi++) begin
        if (wi == 1 && fi > 0 && fi < 4) continue;
        for (int p = 0; p < 9; p++) begin
          pick_pair(p, a, b);
          run_test(a, b, 3'(fi), 1'(wi));
        end
      end
    end

    repeat (N_RANDOM) begin
      rnd = $urandom;
      f3  = rnd[2:0];
      w   = rnd[3];
      if (w && !f3[2]) f3 = muldiv_op_pkg::F3_MUL;
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      case (rnd[5:4])
        2'd1:    b = {56'h0, rnd[15:8]};
        2'd2:    b = {{48{1'b1}}, rnd[23:8]};
        2'd3:    a = {{32{rnd[31]}}, a[31:0]};
        default: ;
      endcase
      run_test(a, b, f3, w);
    end

    // Valid held high so the next request is taken in the response cycle
    for (int i = 0; i < N_BURST; i++) begin
      rnd = $urandom;
      f3  = rnd[2:0];
      w   = rnd[3];
      if (w && !f3[2]) f3 = muldiv_op_pkg::F3_MUL;
      send_request({$urandom, $urandom}, {$urandom, $urandom}, f3, w);
    end
    req_valid_i = 1'b0;
    wait_response();
    repeat (5) @(posedge clk_i);

    if (sent != N_TESTS || accepted != sent || responses != accepted) begin
      $display("Operations lost or duplicated: %0d planned, %0d sent, %0d accepted, %0d answered",
               N_TESTS, sent, accepted, responses);
      top_errors++;
    end
    $display("Summary: %0d tests, %0d responses, %0d errors", sent, responses,
             errors + top_errors);
    if (errors == 0 && top_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* testbench/tb_muldiv_checker.sv */
`timescale 1ns/100ps

module tb_muldiv_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  muldiv_width_pkg::xlen_t operand_a_i,
  input  muldiv_width_pkg::xlen_t operand_b_i,
  input  muldiv_op_pkg::funct3_t  funct3_i,
  input  logic                    word_i,
  input  logic                    req_valid_i,
  input  logic                    req_ready_i,
  input  logic                    resp_valid_i,
  input  muldiv_width_pkg::xlen_t resp_value_i,
  output int                      accepted_o,
  output int                      responses_o,
  output int                      errors_o
);

  logic                    pending_q;
  muldiv_width_pkg::xlen_t expected_q;
  string                   name_q;

  // RISC-V M semantics on 128-bit extended operands
  function automatic logic [63:0] expected_result(
    input logic [63:0] a,
    input logic [63:0] b,
    input logic [2:0]  f3,
    input logic        w
  );
    logic signed [127:0] ea, eb, full, quo, rem;
    logic                a_signed, b_signed;
    logic [63:0]         res;
    if (!f3[2]) begin
      a_signed = f3 != muldiv_op_pkg::F3_MULHU;
      b_signed = (f3 == muldiv_op_pkg::F3_MUL) || (f3 == muldiv_op_pkg::F3_MULH);
      ea = a_signed ? {{64{a[63]}}, a} : {64'h0, a};
      eb = b_signed ? {{64{b[63]}}, b} : {64'h0, b};
      full = ea * eb;
      if (w) res = {{32{full[31]}}, full[31:0]};
      else if (f3 == muldiv_op_pkg::F3_MUL) res = full[63:0];
      else res = full[127:64];
    end else begin
      a_signed = !f3[0];
      if (w) begin
        ea = a_signed ? {{96{a[31]}}, a[31:0]} : {96'h0, a[31:0]};
        eb = a_signed ? {{96{b[31]}}, b[31:0]} : {96'h0, b[31:0]};
      end else begin
        ea = a_signed ? {{64{a[63]}}, a} : {64'h0, a};
        eb = a_signed ? {{64{b[63]}}, b} : {64'h0, b};
      end
      // Divide by zero gives all ones and the dividend back
      if (eb == '0) begin
        quo = '1;
        rem = ea;
      end else begin
        quo = ea / eb;
        rem = ea % eb;
      end
      res = f3[1] ? rem[63:0] : quo[63:0];
      if (w) res = {{32{res[31]}}, res[31:0]};
    end
    return res;
  endfunction

  function automatic string op_name(input logic [2:0] f3, input logic w);
    case ({w, f3})
      4'b0000: return "MUL";
      4'b0001: return "MULH";
      4'b0010: return "MULHSU";
      4'b0011: return "MULHU";
      4'b0100: return "DIV";
      4'b0101: return "DIVU";
      4'b0110: return "REM";
      4'b0111: return "REMU";
      4'b1100: return "DIVW";
      4'b1101: return "DIVUW";
      4'b1110: return "REMW";
      4'b1111: return "REMUW";
      default: return "MULW";
    endcase
  endfunction

  // Sampled on the falling edge where inputs and outputs are stable
  always @(negedge clk_i) begin : watch
    int fails;
    fails = 0;
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      accepted_o  <= 0;
      responses_o <= 0;
      errors_o    <= 0;
    end else begin
      if (resp_valid_i) begin
        if (!pending_q) begin
          $display("Response without an accepted request, value %h", resp_value_i);
          fails++;
        end else if (resp_value_i !== expected_q) begin
          $display("Mismatch resp_value_o in test %0d %s: expected %h, actual %h",
                   responses_o + 1, name_q, expected_q, resp_value_i);
          fails++;
        end else begin
          $display("Test %0d %s passed, result %h", responses_o + 1, name_q, resp_value_i);
        end
        responses_o <= responses_o + 1;
        pending_q   <= 1'b0;
      end else if (pending_q && req_ready_i) begin
        $display("req_ready_o is high while an operation is in flight");
        fails++;
      end
      if (!pending_q && !req_ready_i) begin
        $display("req_ready_o is low with no operation in flight");
        fails++;
      end
      if (req_valid_i && req_ready_i) begin
        expected_q <= expected_result(operand_a_i, operand_b_i, funct3_i, word_i);
        name_q     <= op_name(funct3_i, word_i);
        pending_q  <= 1'b1;
        accepted_o <= accepted_o + 1;
      end
      errors_o <= errors_o + fails;
    end
  end

endmodule

/* vlog.f */
hdl/muldiv_op_pkg.sv
hdl/muldiv_width_pkg.sv
hdl/muldiv_mul.sv
hdl/muldiv_div.sv
hdl/muldiv_dispatch.sv
hdl/muldiv_top.sv
testbench/tb_muldiv_checker.sv
testbench/tb_muldiv.sv
